//--- src/ex_pkg.sv
`default_nettype none

package ex_pkg;

    parameter int XLEN         = 32;
    parameter int REG_ADDR_W   = 5;
    parameter int CACHE_ADDR_W = 21;   // word address into the data cache

    // major opcodes
    parameter logic [6:0] OP_IMM    = 7'b0010011;
    parameter logic [6:0] OP_REG    = 7'b0110011;
    parameter logic [6:0] OP_BRANCH = 7'b1100011;
    parameter logic [6:0] OP_LOAD   = 7'b0000011;
    parameter logic [6:0] OP_STORE  = 7'b0100011;
    parameter logic [6:0] OP_JAL    = 7'b1101111;
    parameter logic [6:0] OP_JALR   = 7'b1100111;
    parameter logic [6:0] OP_LUI    = 7'b0110111;
    parameter logic [6:0] OP_AUIPC  = 7'b0010111;

    // alu group, shared by OP_IMM and OP_REG
    parameter logic [2:0] F3_ADD  = 3'b000;
    parameter logic [2:0] F3_SLL  = 3'b001;
    parameter logic [2:0] F3_SLT  = 3'b010;
    parameter logic [2:0] F3_SLTU = 3'b011;
    parameter logic [2:0] F3_XOR  = 3'b100;
    parameter logic [2:0] F3_SR   = 3'b101;   // srl or sra
    parameter logic [2:0] F3_OR   = 3'b110;
    parameter logic [2:0] F3_AND  = 3'b111;

    // branch group
    parameter logic [2:0] F3_BEQ  = 3'b000;
    parameter logic [2:0] F3_BNE  = 3'b001;
    parameter logic [2:0] F3_BLT  = 3'b100;
    parameter logic [2:0] F3_BGE  = 3'b101;
    parameter logic [2:0] F3_BLTU = 3'b110;
    parameter logic [2:0] F3_BGEU = 3'b111;

    // store group
    parameter logic [2:0] F3_SB = 3'b000;
    parameter logic [2:0] F3_SH = 3'b001;
    parameter logic [2:0] F3_SW = 3'b010;

    parameter logic [6:0] F7_BASE = 7'b0000000;
    parameter logic [6:0] F7_ALT  = 7'b0100000;   // sub, sra

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef struct packed {
        inst_u           inst;
        logic [XLEN-1:0] inst_addr;
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
        logic [XLEN-1:0] op1_jump;
        logic [XLEN-1:0] op2_jump;
        logic [XLEN-1:0] reg1_rdata;
        logic [XLEN-1:0] reg2_rdata;
    } id_ex_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } reg_wb_t;

    typedef struct packed {
        logic            flag;
        logic [XLEN-1:0] addr;
    } jump_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;   // only the low CACHE_ADDR_W bits carry the address
        logic [3:0]      byte_en;
        logic [XLEN-1:0] wdata;
        logic            read;
        logic            write;
    } mem_req_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [1:0]            offset;
        logic [2:0]            funct3;
    } load_wait_t;

endpackage

`default_nettype wire

//--- src/ex_alu.sv
`timescale 1ns/10ps
`default_nettype none

module ex_alu (
    input  ex_pkg::id_ex_t          id_ex_i,
    output logic [ex_pkg::XLEN-1:0] alu_result_o
);

    logic [ex_pkg::XLEN-1:0] op_a;
    logic [ex_pkg::XLEN-1:0] op_b;
    logic [4:0]              shamt;
    logic [ex_pkg::XLEN-1:0] res_add;
    logic [ex_pkg::XLEN-1:0] res_sub;
    logic [ex_pkg::XLEN-1:0] res_sll;
    logic [ex_pkg::XLEN-1:0] res_srl;
    logic [ex_pkg::XLEN-1:0] res_sra;
    logic [ex_pkg::XLEN-1:0] res_slt;
    logic [ex_pkg::XLEN-1:0] res_sltu;
    logic [6:0]              opcode;
    logic [2:0]              funct3;

    assign opcode = id_ex_i.inst.r.opcode;
    assign funct3 = id_ex_i.inst.r.funct3;

    // immediate sits in op1 for OP_IMM
    assign op_a  = id_ex_i.reg1_rdata;
    assign op_b  = (opcode == ex_pkg::OP_IMM) ? id_ex_i.op1 : id_ex_i.reg2_rdata;
    assign shamt = op_b[4:0];

    assign res_add  = op_a + op_b;
    assign res_sub  = op_a - op_b;
    assign res_sll  = op_a << shamt;
    assign res_srl  = op_a >> shamt;
    assign res_sra  = $signed(op_a) >>> shamt;   // fills with bit 31
    assign res_slt  = {{(ex_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
    assign res_sltu = {{(ex_pkg::XLEN-1){1'b0}}, op_a < op_b};

    always_comb begin
        alu_result_o = '0;
        if (opcode == ex_pkg::OP_IMM ||
            (opcode == ex_pkg::OP_REG && id_ex_i.inst.r.funct7 == ex_pkg::F7_BASE)) begin
            case (funct3)
                ex_pkg::F3_ADD:  alu_result_o = res_add;
                ex_pkg::F3_SLL:  alu_result_o = res_sll;
                ex_pkg::F3_SLT:  alu_result_o = res_slt;
                ex_pkg::F3_SLTU: alu_result_o = res_sltu;
                ex_pkg::F3_XOR:  alu_result_o = op_a ^ op_b;
                ex_pkg::F3_OR:   alu_result_o = op_a | op_b;
                ex_pkg::F3_AND:  alu_result_o = op_a & op_b;
                ex_pkg::F3_SR: begin
                    if (opcode == ex_pkg::OP_REG) begin
                        alu_result_o = res_srl;
                    end else if (id_ex_i.inst.i.imm[11:5] == ex_pkg::F7_BASE) begin
                        alu_result_o = res_srl;
                    end else if (id_ex_i.inst.i.imm[11:5] == ex_pkg::F7_ALT) begin
                        alu_result_o = res_sra;   // srai
                    end
                end
                default: alu_result_o = '0;
            endcase
        end else if (opcode == ex_pkg::OP_REG &&
                     id_ex_i.inst.r.funct7 == ex_pkg::F7_ALT) begin
            case (funct3)
                ex_pkg::F3_ADD: alu_result_o = res_sub;
                ex_pkg::F3_SR:  alu_result_o = res_sra;
                default:        alu_result_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/ex_branch.sv
`timescale 1ns/10ps
`default_nettype none

module ex_branch (
    input  ex_pkg::id_ex_t          id_ex_i,
    output ex_pkg::jump_t           jump_o,
    output logic [ex_pkg::XLEN-1:0] link_data_o
);

    logic [ex_pkg::XLEN-1:0] target;
    logic                    eq;
    logic                    lt;
    logic                    ltu;

    assign target = id_ex_i.op1_jump + id_ex_i.op2_jump;

    assign eq  = id_ex_i.reg1_rdata == id_ex_i.reg2_rdata;
    assign lt  = $signed(id_ex_i.reg1_rdata) < $signed(id_ex_i.reg2_rdata);
    assign ltu = id_ex_i.reg1_rdata < id_ex_i.reg2_rdata;

    // return address for jal/jalr
    assign link_data_o = id_ex_i.inst_addr + id_ex_i.op2;

    always_comb begin
        jump_o = '0;
        case (id_ex_i.inst.r.opcode)
            ex_pkg::OP_BRANCH: begin
                jump_o.addr = target;
                case (id_ex_i.inst.r.funct3)
                    ex_pkg::F3_BEQ:  jump_o.flag = eq;
                    ex_pkg::F3_BNE:  jump_o.flag = !eq;
                    ex_pkg::F3_BLT:  jump_o.flag = lt;
                    ex_pkg::F3_BGE:  jump_o.flag = !lt;
                    ex_pkg::F3_BLTU: jump_o.flag = ltu;
                    ex_pkg::F3_BGEU: jump_o.flag = !ltu;
                    default:         jump_o      = '0;   // no such branch
                endcase
            end
            ex_pkg::OP_JAL,
            ex_pkg::OP_JALR: begin
                jump_o.flag = 1'b1;
                jump_o.addr = target;
            end
            default: jump_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/ex_mem_req.sv
`timescale 1ns/10ps
`default_nettype none

module ex_mem_req #(
    parameter int CACHE_ADDR_W = ex_pkg::CACHE_ADDR_W
) (
    input  ex_pkg::id_ex_t     id_ex_i,
    output ex_pkg::mem_req_t   mem_req_o,
    output ex_pkg::load_wait_t load_wait_o,
    output logic               hold_o
);

    logic [ex_pkg::XLEN-1:0] byte_addr;
    logic [ex_pkg::XLEN-1:0] cache_addr;
    logic [1:0]              offset;
    logic [ex_pkg::XLEN-1:0] byte_data;
    logic [15:0]             half;

    assign byte_addr = id_ex_i.reg1_rdata + id_ex_i.op1;
    assign offset    = byte_addr[1:0];
    assign half      = id_ex_i.reg2_rdata[15:0];

    always_comb begin
        cache_addr = '0;
        cache_addr[CACHE_ADDR_W-1:0] = byte_addr[CACHE_ADDR_W+1:2];
    end

    // byte 0 of rs2 moved to the addressed lane
    assign byte_data = {{(ex_pkg::XLEN-8){1'b0}}, id_ex_i.reg2_rdata[7:0]} << {offset, 3'b000};

    always_comb begin
        mem_req_o   = '0;
        load_wait_o = '0;
        hold_o      = 1'b0;
        case (id_ex_i.inst.r.opcode)
            ex_pkg::OP_STORE: begin
                mem_req_o.addr  = cache_addr;
                mem_req_o.write = 1'b1;
                case (id_ex_i.inst.r.funct3)
                    ex_pkg::F3_SB: begin
                        mem_req_o.byte_en = 4'b0001 << offset;
                        mem_req_o.wdata   = byte_data;
                    end
                    ex_pkg::F3_SH: begin
                        // lane follows address bit 1 only
                        mem_req_o.byte_en = offset[1] ? 4'b1100 : 4'b0011;
                        mem_req_o.wdata   = offset[1] ? {half, 16'h0000} : {16'h0000, half};
                    end
                    ex_pkg::F3_SW: begin
                        mem_req_o.byte_en = 4'b1111;
                        mem_req_o.wdata   = id_ex_i.reg2_rdata;
                    end
                    default: mem_req_o = '0;
                endcase
            end
            ex_pkg::OP_LOAD: begin
                mem_req_o.addr     = cache_addr;
                mem_req_o.read     = 1'b1;
                load_wait_o.rd     = id_ex_i.inst.i.rd;
                load_wait_o.offset = offset;   // write-back picks the lane
                load_wait_o.funct3 = id_ex_i.inst.i.funct3;
                hold_o             = 1'b1;
            end
            default: begin
                mem_req_o   = '0;
                load_wait_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/ex_commit.sv
`timescale 1ns/10ps
`default_nettype none

module ex_commit (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  ex_pkg::id_ex_t          id_ex_i,
    input  logic [ex_pkg::XLEN-1:0] alu_result_i,
    input  logic [ex_pkg::XLEN-1:0] link_data_i,
    input  ex_pkg::jump_t           branch_jump_i,
    input  ex_pkg::mem_req_t        mem_req_i,
    input  ex_pkg::load_wait_t      load_wait_i,
    input  logic                    hold_i,
    output ex_pkg::reg_wb_t         reg_wb_o,
    output ex_pkg::jump_t           jump_o,
    output ex_pkg::mem_req_t        mem_req_o,
    output ex_pkg::load_wait_t      load_wait_o,
    output logic                    hold_flag_o
);

    ex_pkg::reg_wb_t wb_next;
    logic            alu_ok;
    logic [6:0]      opcode;
    logic [2:0]      funct3;

    assign opcode = id_ex_i.inst.r.opcode;
    assign funct3 = id_ex_i.inst.r.funct3;

    // which alu codes actually exist
    always_comb begin
        case (opcode)
            ex_pkg::OP_IMM: begin
                alu_ok = (funct3 != ex_pkg::F3_SR) ||
                         (id_ex_i.inst.i.imm[11:5] == ex_pkg::F7_BASE) ||
                         (id_ex_i.inst.i.imm[11:5] == ex_pkg::F7_ALT);
            end
            ex_pkg::OP_REG: begin
                alu_ok = (id_ex_i.inst.r.funct7 == ex_pkg::F7_BASE) ||
                         (id_ex_i.inst.r.funct7 == ex_pkg::F7_ALT &&
                          (funct3 == ex_pkg::F3_ADD || funct3 == ex_pkg::F3_SR));
            end
            default: alu_ok = 1'b0;
        endcase
    end

    always_comb begin
        wb_next = '0;
        case (opcode)
            ex_pkg::OP_IMM,
            ex_pkg::OP_REG: begin
                wb_next.we    = alu_ok;
                wb_next.wdata = alu_ok ? alu_result_i : '0;
            end
            ex_pkg::OP_JAL,
            ex_pkg::OP_JALR: begin
                wb_next.we    = 1'b1;
                wb_next.wdata = link_data_i;
            end
            ex_pkg::OP_LUI: begin
                wb_next.we    = 1'b1;
                wb_next.wdata = id_ex_i.op2;   // upper immediate, already shifted
            end
            ex_pkg::OP_AUIPC: begin
                wb_next.we    = 1'b1;
                wb_next.wdata = id_ex_i.op2 + id_ex_i.inst_addr;
            end
            default: wb_next = '0;
        endcase
        // idle bus when nothing is written
        wb_next.waddr = wb_next.we ? id_ex_i.inst.r.rd : '0;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reg_wb_o    <= '0;
            jump_o      <= '0;
            mem_req_o   <= '0;
            load_wait_o <= '0;
            hold_flag_o <= 1'b0;
        end else begin
            reg_wb_o    <= wb_next;
            jump_o      <= branch_jump_i;
            mem_req_o   <= mem_req_i;
            load_wait_o <= load_wait_i;
            hold_flag_o <= hold_i;
        end
    end

endmodule

`default_nettype wire

//--- src/ex_stage.sv
`timescale 1ns/10ps
`default_nettype none

module ex_stage #(
    parameter int CACHE_ADDR_W = ex_pkg::CACHE_ADDR_W
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  ex_pkg::id_ex_t     id_ex_i,
    output ex_pkg::reg_wb_t    reg_wb_o,
    output ex_pkg::jump_t      jump_o,
    output ex_pkg::mem_req_t   mem_req_o,
    output ex_pkg::load_wait_t load_wait_o,
    output logic               hold_flag_o
);

    logic [ex_pkg::XLEN-1:0] alu_result;
    logic [ex_pkg::XLEN-1:0] link_data;
    ex_pkg::jump_t           branch_jump;
    ex_pkg::mem_req_t        mem_req_next;
    ex_pkg::load_wait_t      load_wait_next;
    logic                    load_hold;

    ex_alu u_alu (
        .id_ex_i      (id_ex_i),
        .alu_result_o (alu_result)
    );

    ex_branch u_branch (
        .id_ex_i     (id_ex_i),
        .jump_o      (branch_jump),
        .link_data_o (link_data)
    );

    ex_mem_req #(
        .CACHE_ADDR_W (CACHE_ADDR_W)
    ) u_mem_req (
        .id_ex_i     (id_ex_i),
        .mem_req_o   (mem_req_next),
        .load_wait_o (load_wait_next),
        .hold_o      (load_hold)
    );

    // single register stage for all results
    ex_commit u_commit (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .id_ex_i       (id_ex_i),
        .alu_result_i  (alu_result),
        .link_data_i   (link_data),
        .branch_jump_i (branch_jump),
        .mem_req_i     (mem_req_next),
        .load_wait_i   (load_wait_next),
        .hold_i        (load_hold),
        .reg_wb_o      (reg_wb_o),
        .jump_o        (jump_o),
        .mem_req_o     (mem_req_o),
        .load_wait_o   (load_wait_o),
        .hold_flag_o   (hold_flag_o)
    );

endmodule

`default_nettype wire

//--- verification/ex_tb_clk.sv
`timescale 1ns/10ps
`default_nettype none

module ex_tb_clk #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // flops stay in reset through the releasing edge
    initial begin
        arst_n_o <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/ex_tb_ref.svh
`ifndef EX_TB_REF_SVH
`define EX_TB_REF_SVH

typedef struct packed {
    ex_pkg::reg_wb_t    reg_wb;
    ex_pkg::jump_t      jump;
    ex_pkg::mem_req_t   mem_req;
    ex_pkg::load_wait_t load_wait;
    logic               hold;
} stage_out_t;

// logical shift plus a mask of sign bits
function automatic logic [31:0] shift_right_arith(input logic [31:0] a, input logic [4:0] sh);
    return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
endfunction

function automatic logic less_signed(input logic [31:0] a, input logic [31:0] b);
    return (a[31] != b[31]) ? a[31] : (a < b);
endfunction

function automatic stage_out_t predict_outputs(input ex_pkg::id_ex_t in, input int cache_w);
    stage_out_t  o;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [31:0] res;
    logic        ok;
    logic [1:0]  off;
    o   = '0;
    w   = in.inst;
    a   = in.reg1_rdata;
    b   = (w[6:0] == ex_pkg::OP_IMM) ? in.op1 : in.reg2_rdata;
    ea  = in.reg1_rdata + in.op1;
    off = ea[1:0];
    res = '0;
    ok  = 1'b1;
    case (w[6:0])
        ex_pkg::OP_IMM, ex_pkg::OP_REG: begin
            if (w[6:0] == ex_pkg::OP_REG && w[31:25] == ex_pkg::F7_ALT) begin
                case (w[14:12])
                    ex_pkg::F3_ADD: res = a - b;
                    ex_pkg::F3_SR:  res = shift_right_arith(a, b[4:0]);
                    default:        ok = 1'b0;
                endcase
            end else if (w[6:0] == ex_pkg::OP_REG && w[31:25] != ex_pkg::F7_BASE) begin
                ok = 1'b0;
            end else begin
                case (w[14:12])
                    ex_pkg::F3_ADD:  res = a + b;
                    ex_pkg::F3_SLL:  res = a << b[4:0];
                    ex_pkg::F3_SLT:  res = {31'b0, less_signed(a, b)};
                    ex_pkg::F3_SLTU: res = {31'b0, a < b};
                    ex_pkg::F3_XOR:  res = a ^ b;
                    ex_pkg::F3_OR:   res = a | b;
                    ex_pkg::F3_AND:  res = a & b;
                    default: begin   // shift right, type in the top seven bits
                        if (w[31:25] == ex_pkg::F7_BASE) res = a >> b[4:0];
                        else if (w[31:25] == ex_pkg::F7_ALT) res = shift_right_arith(a, b[4:0]);
                        else ok = 1'b0;
                    end
                endcase
            end
            if (ok) o.reg_wb = {1'b1, w[11:7], res};
        end
        ex_pkg::OP_BRANCH: begin
            o.jump.addr = in.op1_jump + in.op2_jump;
            case (w[14:12])
                ex_pkg::F3_BEQ:  o.jump.flag = (a == b);
                ex_pkg::F3_BNE:  o.jump.flag = (a != b);
                ex_pkg::F3_BLT:  o.jump.flag = less_signed(a, b);
                ex_pkg::F3_BGE:  o.jump.flag = !less_signed(a, b);
                ex_pkg::F3_BLTU: o.jump.flag = (a < b);
                ex_pkg::F3_BGEU: o.jump.flag = !(a < b);
                default:         o.jump = '0;
            endcase
        end
        ex_pkg::OP_JAL, ex_pkg::OP_JALR: begin
            o.jump   = {1'b1, in.op1_jump + in.op2_jump};
            o.reg_wb = {1'b1, w[11:7], in.inst_addr + in.op2};   // return address
        end
        ex_pkg::OP_LUI:   o.reg_wb = {1'b1, w[11:7], in.op2};
        ex_pkg::OP_AUIPC: o.reg_wb = {1'b1, w[11:7], in.op2 + in.inst_addr};
        ex_pkg::OP_STORE: begin
            o.mem_req.addr  = (ea >> 2) & ((32'h1 << cache_w) - 1);
            o.mem_req.write = 1'b1;
            case (w[14:12])
                ex_pkg::F3_SB: begin
                    o.mem_req.byte_en = 4'b0001 << off;
                    o.mem_req.wdata   = {24'h0, in.reg2_rdata[7:0]} << (8 * off);
                end
                ex_pkg::F3_SH: begin
                    o.mem_req.byte_en = off[1] ? 4'b1100 : 4'b0011;
                    o.mem_req.wdata   = off[1] ? {in.reg2_rdata[15:0], 16'h0}
                                               : {16'h0, in.reg2_rdata[15:0]};
                end
                ex_pkg::F3_SW: begin
                    o.mem_req.byte_en = 4'b1111;
                    o.mem_req.wdata   = in.reg2_rdata;
                end
                default: o.mem_req = '0;
            endcase
        end
        ex_pkg::OP_LOAD: begin
            o.mem_req.addr = (ea >> 2) & ((32'h1 << cache_w) - 1);
            o.mem_req.read = 1'b1;
            o.load_wait    = {w[11:7], off, w[14:12]};
            o.hold         = 1'b1;
        end
        default: o = '0;
    endcase
    return o;
endfunction

`endif

//--- verification/ex_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ex_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int CACHE_W     = ex_pkg::CACHE_ADDR_W;
    localparam int NUM_ALU     = 240;
    localparam int NUM_BR      = 160;
    localparam int NUM_UPPER   = 40;
    localparam int NUM_STORE   = 48;   // three sizes, four offsets, four rounds
    localparam int NUM_LOAD    = 100;
    localparam int TOTAL_VEC   = NUM_ALU + NUM_BR + NUM_UPPER + NUM_STORE + NUM_LOAD;
    localparam int WATCHDOG_NS = (TOTAL_VEC + 50) * CLK_PERIOD;

    logic               clk;
    logic               arst_n;
    ex_pkg::id_ex_t     id_ex;
    ex_pkg::reg_wb_t    reg_wb;
    ex_pkg::jump_t      jump;
    ex_pkg::mem_req_t   mem_req;
    ex_pkg::load_wait_t load_wait;
    logic               hold_flag;
    ex_pkg::id_ex_t     in_flight;   // record the output register holds
    logic               rst_q;
    logic               vec_valid;     // id_ex carries a queued record
    logic               vec_valid_q;
    ex_pkg::id_ex_t     vec_q[$];
    int                 compare_count = 0;

    `include "ex_tb_ref.svh"

    ex_tb_clk #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(10)) u_clk (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    ex_stage #(.CACHE_ADDR_W(CACHE_W)) dut (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .id_ex_i     (id_ex),
        .reg_wb_o    (reg_wb),
        .jump_o      (jump),
        .mem_req_o   (mem_req),
        .load_wait_o (load_wait),
        .hold_flag_o (hold_flag)
    );

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // kind 0 imm alu, 1 reg alu, 2 branch, 3 jal, 4 jalr, 5 lui, 6 auipc, else load
    function automatic ex_pkg::id_ex_t random_record(input int kind);
        ex_pkg::id_ex_t r;
        logic [31:0]    w;
        logic [6:0]     f7;
        r            = '0;
        w            = $urandom;
        r.inst_addr  = $urandom & 32'hffff_fffc;
        r.reg1_rdata = $urandom;
        r.reg2_rdata = $urandom;
        case ($urandom_range(0, 3))   // mostly legal funct7
            0, 1:    f7 = ex_pkg::F7_BASE;
            2:       f7 = ex_pkg::F7_ALT;
            default: f7 = w[31:25];
        endcase
        case (kind)
            0: begin
                w[6:0] = ex_pkg::OP_IMM;
                if (w[14:12] == ex_pkg::F3_SR) w[31:25] = f7;
                r.op1 = sext12(w[31:20]);
            end
            1: begin
                w[6:0]   = ex_pkg::OP_REG;
                w[31:25] = f7;
            end
            2: begin
                w[6:0] = ex_pkg::OP_BRANCH;
                case ($urandom_range(0, 5))
                    0:       w[14:12] = ex_pkg::F3_BEQ;
                    1:       w[14:12] = ex_pkg::F3_BNE;
                    2:       w[14:12] = ex_pkg::F3_BLT;
                    3:       w[14:12] = ex_pkg::F3_BGE;
                    4:       w[14:12] = ex_pkg::F3_BLTU;
                    default: w[14:12] = ex_pkg::F3_BGEU;
                endcase
                case ($urandom_range(0, 3))
                    0: r.reg2_rdata = r.reg1_rdata;
                    1: begin
                        r.reg1_rdata[31] = 1'b1;
                        r.reg2_rdata[31] = 1'b1;
                    end
                    2: begin   // large unsigned against small
                        r.reg1_rdata[31:16] = 16'hffff;
                        r.reg2_rdata[31:16] = 16'h0000;
                    end
                    default: ;
                endcase
                r.op1_jump = r.inst_addr;
                r.op2_jump = sext12({w[31], w[7], w[30:25], w[11:8]}) << 1;
            end
            3: begin
                w[6:0]     = ex_pkg::OP_JAL;
                r.op1_jump = r.inst_addr;
                r.op2_jump = sext12(w[31:20]) << 1;
                r.op2      = 4;
            end
            4: begin
                w[6:0]     = ex_pkg::OP_JALR;
                w[14:12]   = 3'b000;
                r.op1_jump = r.reg1_rdata;
                r.op2_jump = sext12(w[31:20]);
                r.op2      = 4;
            end
            5, 6: begin
                w[6:0] = (kind == 5) ? ex_pkg::OP_LUI : ex_pkg::OP_AUIPC;
                r.op2  = {w[31:12], 12'h000};
            end
            default: begin
                w[6:0] = ex_pkg::OP_LOAD;
                r.op1  = sext12(w[31:20]);
            end
        endcase
        r.inst = w;
        return r;
    endfunction

    // base register chosen so the byte address lands on the wanted offset
    function automatic ex_pkg::id_ex_t store_record(input logic [2:0] f3, input logic [1:0] off);
        ex_pkg::id_ex_t r;
        logic [31:0]    w;
        logic [31:0]    ea;
        r            = '0;
        w            = $urandom;
        w[6:0]       = ex_pkg::OP_STORE;
        w[14:12]     = f3;
        ea           = $urandom;
        ea[1:0]      = off;
        r.op1        = sext12({w[31:25], w[11:7]});
        r.reg1_rdata = ea - r.op1;
        r.reg2_rdata = $urandom;
        r.inst_addr  = $urandom & 32'hffff_fffc;
        r.inst       = w;
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] expv,
                               input logic [31:0] gotv);
        assert (gotv === expv) else begin
            $display("ERR %s expected %h actual %h", name, expv, gotv);
            $display("Done: errors found");
            $fatal(1, "output mismatch");
        end
    endtask

    always @(posedge clk) begin
        in_flight   <= id_ex;
        rst_q       <= arst_n;
        vec_valid_q <= vec_valid;
    end

    // outputs settle after the rising edge, so compare on the falling one
    always @(negedge clk) begin
        stage_out_t exp_out;
        if (!$isunknown(rst_q)) begin   // nothing sampled before the first edge
            exp_out = rst_q ? predict_outputs(in_flight, CACHE_W) : '0;
            check_field("reg_wb_o.we", 32'(exp_out.reg_wb.we), 32'(reg_wb.we));
            check_field("reg_wb_o.waddr", 32'(exp_out.reg_wb.waddr), 32'(reg_wb.waddr));
            check_field("reg_wb_o.wdata", exp_out.reg_wb.wdata, reg_wb.wdata);
            check_field("jump_o.flag", 32'(exp_out.jump.flag), 32'(jump.flag));
            check_field("jump_o.addr", exp_out.jump.addr, jump.addr);
            check_field("mem_req_o.addr", exp_out.mem_req.addr, mem_req.addr);
            check_field("mem_req_o.byte_en", 32'(exp_out.mem_req.byte_en),
                        32'(mem_req.byte_en));
            check_field("mem_req_o.wdata", exp_out.mem_req.wdata, mem_req.wdata);
            check_field("mem_req_o.read", 32'(exp_out.mem_req.read), 32'(mem_req.read));
            check_field("mem_req_o.write", 32'(exp_out.mem_req.write), 32'(mem_req.write));
            check_field("load_wait_o.rd", 32'(exp_out.load_wait.rd), 32'(load_wait.rd));
            check_field("load_wait_o.offset", 32'(exp_out.load_wait.offset),
                        32'(load_wait.offset));
            check_field("load_wait_o.funct3", 32'(exp_out.load_wait.funct3),
                        32'(load_wait.funct3));
            check_field("hold_flag_o", 32'(exp_out.hold), 32'(hold_flag));
            if (rst_q && vec_valid_q) compare_count++;
        end
    end

    initial begin
        id_ex     <= '0;
        vec_valid <= 1'b0;
        void'($urandom(32'h7ce2_0bd7));
        for (int i = 0; i < NUM_ALU; i++) begin
            vec_q.push_back(random_record(i % 2));
        end
        for (int i = 0; i < NUM_BR; i++) begin
            vec_q.push_back(random_record(2 + (i % 8) / 6 * (i % 2 + 1)));
        end
        for (int i = 0; i < NUM_UPPER; i++) begin
            vec_q.push_back(random_record(5 + i % 2));
        end
        for (int i = 0; i < NUM_STORE; i++) begin
            vec_q.push_back(store_record(3'(i % 3), 2'(i / 3)));
        end
        // short load bursts with other work between them
        for (int i = 0; i < NUM_LOAD; i++) begin
            vec_q.push_back(random_record((i % 5 < 3) ? 7 : int'($urandom_range(0, 6))));
        end
        wait (arst_n === 1'b1);
        @(posedge clk);
        foreach (vec_q[i]) begin
            id_ex     <= vec_q[i];
            vec_valid <= 1'b1;
            @(posedge clk);
        end
        id_ex     <= '0;
        vec_valid <= 1'b0;
        repeat (3) @(posedge clk);
        if (compare_count == vec_q.size()) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("only %0d of %0d records were compared", compare_count, vec_q.size());
            $display("Done: errors found");
            $fatal(1, "incomplete run");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: stimulus did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+verification
src/ex_pkg.sv
src/ex_alu.sv
src/ex_branch.sv
src/ex_mem_req.sv
src/ex_commit.sv
src/ex_stage.sv
verification/ex_tb_clk.sv
verification/ex_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the execute stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module ex_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out="$(./obj_dir/Vex_tb 2>&1)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "pass message not found"
exit 1
